// File: muldiv_pkg.sv
/* Shared definitions of the multiply/divide unit with the operation
   encoding, request struct and opcode classification helpers */
package muldiv_pkg;

    localparam int XLEN_MAX = 64;

    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } muldiv_op_e;

    // src1 is the multiplicand or dividend and src2 the multiplier or divisor
    typedef struct packed {
        muldiv_op_e          op;
        logic [XLEN_MAX-1:0] src1;
        logic [XLEN_MAX-1:0] src2;
    } muldiv_req_t;

    // ----------------------------------------------------------
    // Opcode classification
    // ----------------------------------------------------------
    function automatic logic is_div_op(muldiv_op_e op);
        return op inside {op_div, op_divu, op_rem, op_remu};
    endfunction

    // Upper result word is the high product half or the remainder
    function automatic logic is_high_op(muldiv_op_e op);
        return op inside {op_mulh, op_mulhsu, op_mulhu, op_rem, op_remu};
    endfunction

    function automatic logic is_signed_a(muldiv_op_e op);
        return op inside {op_mul, op_mulh, op_mulhsu, op_div, op_rem};
    endfunction

    function automatic logic is_signed_b(muldiv_op_e op);
        return op inside {op_mul, op_mulh, op_div, op_rem};
    endfunction

endpackage

// File: mul_iter.sv
`timescale 1ns/1ps
/* Bit-serial shift-and-add multiplier, one multiplier bit per cycle,
   signed or unsigned operands, double-width product */
module mul_iter import muldiv_pkg::*; #(
    parameter int XLEN = XLEN_MAX
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              flush,
    input  logic              start,
    input  logic              a_signed,
    input  logic              b_signed,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    output logic [2*XLEN-1:0] product,
    output logic              done
);

    localparam int CNT_W = $clog2(XLEN + 2);
    localparam logic [CNT_W-1:0] LAST_STEP    = CNT_W'(XLEN);
    localparam logic [CNT_W-1:0] RESULT_CYCLE = CNT_W'(XLEN + 1);

    logic [CNT_W-1:0]  count;
    logic              run;
    logic              zero_op;
    logic              step;
    logic [2*XLEN-1:0] prod_q;
    logic [XLEN-1:0]   acc_hi;
    logic [XLEN:0]     acc_ext;
    logic [XLEN:0]     mcand_ext;
    logic [XLEN:0]     sum;

    // ----------------------------------------------------------
    // Step control
    // ----------------------------------------------------------
    assign run     = start & ~flush;
    assign zero_op = (a == '0) || (b == '0);
    assign step    = run && (count != '0) && (count <= LAST_STEP);
    assign done    = run && (zero_op || (count == RESULT_CYCLE));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!run || done) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Datapath
    // ----------------------------------------------------------
    assign acc_hi = prod_q[2*XLEN-1:XLEN];

    // Extra top bit holds the sign for signed a, the carry otherwise
    assign acc_ext   = {a_signed & acc_hi[XLEN-1], acc_hi};
    assign mcand_ext = {a_signed & a[XLEN-1], a};

    always_comb begin
        if (!prod_q[0]) begin
            sum = acc_ext;
        end else if (b_signed && (count == LAST_STEP)) begin
            // Multiplier MSB carries negative weight
            sum = acc_ext - mcand_ext;
        end else begin
            sum = acc_ext + mcand_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (run && (count == '0)) begin
            prod_q <= {{XLEN{1'b0}}, b};
        end else if (step) begin
            prod_q <= {sum, prod_q[XLEN-1:1]};
        end
    end

    assign product = zero_op ? '0 : prod_q;

endmodule

// File: div_iter.sv
`timescale 1ns/1ps
/* Bit-serial restoring divider with RISC-V results for divide by zero
   and signed overflow */
module div_iter import muldiv_pkg::*; #(
    parameter int XLEN = XLEN_MAX
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            start,
    input  logic            is_signed,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] quotient,
    output logic [XLEN-1:0] remainder,
    output logic            done
);

    localparam int CNT_W = $clog2(XLEN + 2);
    localparam logic [CNT_W-1:0] LAST_STEP    = CNT_W'(XLEN);
    localparam logic [CNT_W-1:0] RESULT_CYCLE = CNT_W'(XLEN + 1);
    localparam logic [XLEN-1:0]  MOST_NEG     = {1'b1, {(XLEN-1){1'b0}}};

    logic [CNT_W-1:0] count;
    logic             run;
    logic             step;
    logic             a_neg;
    logic             b_neg;
    logic             div_zero;
    logic             overflow;
    logic [XLEN-1:0]  a_mag;
    logic [XLEN-1:0]  b_mag;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  dvs_q;
    logic [XLEN:0]    shifted;
    logic [XLEN+1:0]  diff;
    logic [XLEN-1:0]  quo_fix;
    logic [XLEN-1:0]  rem_fix;

    assign a_neg    = is_signed & a[XLEN-1];
    assign b_neg    = is_signed & b[XLEN-1];
    assign a_mag    = a_neg ? -a : a;
    assign b_mag    = b_neg ? -b : b;
    assign div_zero = (b == '0);
    assign overflow = is_signed && (a == MOST_NEG) && (b == '1);

    // ----------------------------------------------------------
    // Step control
    // ----------------------------------------------------------
    assign run  = start & ~flush;
    assign step = run && (count != '0) && (count <= LAST_STEP);
    assign done = run && (div_zero || overflow || (count == RESULT_CYCLE));

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!run || done) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Restoring steps
    // ----------------------------------------------------------
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = {1'b0, shifted} - {2'b00, dvs_q};

    always_ff @(posedge clk) begin
        if (run && (count == '0)) begin
            rem_q <= '0;
            quo_q <= a_mag;
            dvs_q <= b_mag;
        end else if (step) begin
            if (diff[XLEN+1]) begin
                // Trial went negative so the shifted value stays
                rem_q <= shifted[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end else begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end
        end
    end

    // Quotient rounds toward zero and the remainder follows the dividend
    assign quo_fix = (a_neg ^ b_neg) ? -quo_q : quo_q;
    assign rem_fix = a_neg ? -rem_q : rem_q;

    always_comb begin
        if (div_zero) begin
            quotient  = '1;
            remainder = a;
        end else if (overflow) begin
            quotient  = a;
            remainder = '0;
        end else begin
            quotient  = quo_fix;
            remainder = rem_fix;
        end
    end

endmodule

// File: muldiv_unit.sv
`timescale 1ns/1ps
/* Multiply/divide unit top level that decodes the M-extension op, runs
   one iterative engine and selects the result word */
module muldiv_unit import muldiv_pkg::*; #(
    parameter int XLEN = XLEN_MAX
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            flush,
    input  logic            req_valid,
    input  muldiv_req_t     req,
    output logic [XLEN-1:0] result,
    output logic            done
);

    muldiv_op_e        op;
    logic              div_sel;
    logic              high_sel;
    logic [XLEN-1:0]   src_a;
    logic [XLEN-1:0]   src_b;
    logic              mul_start;
    logic              div_start;
    logic              mul_done;
    logic              div_done;
    logic [2*XLEN-1:0] product;
    logic [XLEN-1:0]   quotient;
    logic [XLEN-1:0]   remainder;

    // ----------------------------------------------------------
    // Decode
    // ----------------------------------------------------------
    assign op       = req.op;
    assign div_sel  = is_div_op(op);
    assign high_sel = is_high_op(op);
    assign src_a    = req.src1[XLEN-1:0];
    assign src_b    = req.src2[XLEN-1:0];

    // Only one engine sees the request
    assign mul_start = req_valid & ~div_sel;
    assign div_start = req_valid & div_sel;

    mul_iter #(
        .XLEN(XLEN)
    ) i_mul_iter (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .start    (mul_start),
        .a_signed (is_signed_a(op)),
        .b_signed (is_signed_b(op)),
        .a        (src_a),
        .b        (src_b),
        .product  (product),
        .done     (mul_done)
    );

    div_iter #(
        .XLEN(XLEN)
    ) i_div_iter (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .start     (div_start),
        .is_signed (is_signed_a(op)),
        .a         (src_a),
        .b         (src_b),
        .quotient  (quotient),
        .remainder (remainder),
        .done      (div_done)
    );

    // ----------------------------------------------------------
    // Result select
    // ----------------------------------------------------------
    always_comb begin
        case ({div_sel, high_sel})
            2'b00:   result = product[XLEN-1:0];
            2'b01:   result = product[2*XLEN-1:XLEN];
            2'b10:   result = quotient;
            default: result = remainder;
        endcase
    end

    assign done = div_sel ? div_done : mul_done;

endmodule

// File: muldiv_checker.sv
`timescale 1ns/1ps
/* Done strobe and reset assertions for the multiply/divide unit */
module muldiv_checker #(
    parameter int XLEN = 64
) (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic req_valid,
    input logic done
);

    int valid_run;

    // Request cycles without flush since the last done
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_run <= 0;
        end else if (!req_valid || flush || done) begin
            valid_run <= 0;
        end else begin
            valid_run <= valid_run + 1;
        end
    end

    // ----------------------------------------------------------
    // Done strobe rules
    // ----------------------------------------------------------
    a_done_needs_valid: assert property (@(posedge clk) disable iff (reset) done |-> req_valid)
        else $error("done high without req_valid");

    a_done_low_in_reset: assert property (@(posedge clk) reset |-> !done)
        else $error("done high during reset");

    a_done_low_after_reset: assert property (@(posedge clk) $past(reset) |-> !done)
        else $error("done high in the cycle after reset");

    a_done_low_after_flush: assert property (@(posedge clk) disable iff (reset)
        $past(flush) |-> !done)
        else $error("done high in the cycle after flush");

    a_done_in_time: assert property (@(posedge clk) disable iff (reset)
        (req_valid && !flush && (valid_run == XLEN + 1)) |-> done)
        else $error("done missing after XLEN+2 request cycles");

endmodule

// File: tb_muldiv.sv
`timescale 1ns/1ps
/* Testbench for the multiply/divide unit with directed and random
   requests checked against a 128-bit reference model */
module tb_muldiv import muldiv_pkg::*; ();

    localparam int XLEN       = 64;
    localparam int CLK_PERIOD = 4;
    localparam int N_RAND_MUL = 200;
    localparam int N_RAND_DIV = 50;
    // Requests of all test groups in run order
    localparam int N_REQUESTS = 5 + 27 + 3 * N_RAND_MUL + 4 + 24 + 4 * N_RAND_DIV + 12 + 4;
    localparam int TIMEOUT_NS = N_REQUESTS * (XLEN + 4) * CLK_PERIOD + 1000;
    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic            clk;
    logic            reset;
    logic            flush;
    logic            req_valid;
    muldiv_req_t     req;
    logic [XLEN-1:0] result;
    logic            done;
    int              errors = 0;
    logic [31:0]     rng_state = 32'h976;

    muldiv_unit #(
        .XLEN(XLEN)
    ) i_muldiv_unit (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .req_valid (req_valid),
        .req       (req),
        .result    (result),
        .done      (done)
    );

    bind muldiv_unit muldiv_checker #(
        .XLEN(XLEN)
    ) i_muldiv_checker (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .req_valid (req_valid),
        .done      (done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------
    // Reference model and helpers
    // ----------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [XLEN-1:0] model_result(input muldiv_op_e op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        logic signed [2*XLEN-1:0] wa;
        logic signed [2*XLEN-1:0] wb;
        logic signed [2*XLEN-1:0] prod;
        logic signed [2*XLEN-1:0] quo;
        logic signed [2*XLEN-1:0] rem;
        wa = is_signed_a(op) ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
        wb = is_signed_b(op) ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
        if (!is_div_op(op)) begin
            prod = wa * wb;
            return is_high_op(op) ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
        end
        if (b == '0) begin
            return is_high_op(op) ? a : {XLEN{1'b1}};
        end
        if (is_signed_a(op) && (a == MOST_NEG) && (b == {XLEN{1'b1}})) begin
            return is_high_op(op) ? {XLEN{1'b0}} : a;
        end
        // Signed division truncates and the remainder follows the dividend
        quo = wa / wb;
        rem = wa % wb;
        return is_high_op(op) ? rem[XLEN-1:0] : quo[XLEN-1:0];
    endfunction

    function automatic int expected_cycles(input muldiv_op_e op, input logic [XLEN-1:0] a,
                                           input logic [XLEN-1:0] b);
        if (!is_div_op(op)) begin
            return ((a == '0) || (b == '0)) ? 1 : XLEN + 2;
        end
        if ((b == '0) || (is_signed_a(op) && (a == MOST_NEG) && (b == {XLEN{1'b1}}))) begin
            return 1;
        end
        return XLEN + 2;
    endfunction

    task automatic next_operand(output logic [XLEN-1:0] v);
        logic [31:0] hi;
        rng_state = xorshift(rng_state);
        hi        = rng_state;
        rng_state = xorshift(rng_state);
        v         = {hi, rng_state};
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                               input logic [XLEN-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One request held until done or until the cycle bound runs out
    task automatic run_request(input string name, input muldiv_op_e op,
                               input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int              cycles;
        logic            seen;
        logic [XLEN-1:0] got;
        cycles = 1;
        seen   = 1'b0;
        got    = '0;
        @(negedge clk);
        req_valid = 1'b1;
        flush     = 1'b0;
        req.op    = op;
        req.src1  = a;
        req.src2  = b;
        while (!seen && (cycles <= XLEN + 4)) begin
            #1;
            if (done) begin
                seen = 1'b1;
                got  = result;
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
        if (seen) begin
            @(negedge clk);
        end
        req_valid = 1'b0;
        if (!seen) begin
            errors++;
            $display("ERROR: %s: done did not arrive within %0d cycles", name, XLEN + 4);
        end else begin
            check_value({name, " result"}, model_result(op, a, b), got);
            check_value({name, " cycles"}, XLEN'(expected_cycles(op, a, b)), XLEN'(cycles));
        end
    endtask

    // ----------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------
    task automatic low_word_products();
        run_request("mul small", op_mul, 64'd3, 64'd5);
        run_request("mul medium", op_mul, 64'd1000, 64'd123456789);
        run_request("mul neg by pos", op_mul, -64'sd6, 64'd7);
        run_request("mul minus one squared", op_mul, {XLEN{1'b1}}, {XLEN{1'b1}});
        run_request("mul wide", op_mul, 64'h1234_5678_9abc_def0, 64'h0fed_cba9_8765_4321);
    endtask

    task automatic high_word_products();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] edges [3];
        muldiv_op_e      ops [3];
        edges = '{MOST_NEG, {XLEN{1'b1}}, 64'd1};
        ops   = '{op_mulh, op_mulhsu, op_mulhu};
        foreach (edges[i]) begin
            foreach (edges[j]) begin
                foreach (ops[k]) begin
                    run_request($sformatf("%s edge %0d %0d", ops[k].name(), i, j),
                                ops[k], edges[i], edges[j]);
                end
            end
        end
        repeat (N_RAND_MUL) begin
            next_operand(a);
            next_operand(b);
            foreach (ops[k]) begin
                run_request($sformatf("%s random", ops[k].name()), ops[k], a, b);
            end
        end
    endtask

    task automatic zero_operand_products();
        run_request("mul zero a", op_mul, '0, 64'h1234_5678);
        run_request("mul zero b", op_mul, 64'hdead_beef, '0);
        run_request("mulhu zero a", op_mulhu, '0, {XLEN{1'b1}});
        run_request("mulhu zero b", op_mulhu, MOST_NEG, '0);
    endtask

    task automatic divide_and_remainder();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] dvd [6];
        logic [XLEN-1:0] dvs [6];
        muldiv_op_e      ops [4];
        dvd = '{64'd20, -64'sd20, 64'd20, -64'sd20, 64'd7, 64'd5};
        dvs = '{64'd3, 64'd3, -64'sd3, -64'sd3, 64'd7, 64'd9};
        ops = '{op_div, op_divu, op_rem, op_remu};
        foreach (dvd[i]) begin
            foreach (ops[k]) begin
                run_request($sformatf("%s signs %0d", ops[k].name(), i), ops[k], dvd[i], dvs[i]);
            end
        end
        repeat (N_RAND_DIV) begin
            next_operand(a);
            next_operand(b);
            // Shorter divisors give larger quotients
            b = b >> rng_state[5:0];
            foreach (ops[k]) begin
                run_request($sformatf("%s random", ops[k].name()), ops[k], a, b);
            end
        end
    endtask

    task automatic special_divides();
        muldiv_op_e ops [4];
        ops = '{op_div, op_divu, op_rem, op_remu};
        foreach (ops[k]) begin
            run_request($sformatf("%s by zero", ops[k].name()), ops[k], 64'h1234, '0);
            run_request($sformatf("%s most neg by zero", ops[k].name()), ops[k], MOST_NEG, '0);
        end
        run_request("div overflow", op_div, MOST_NEG, {XLEN{1'b1}});
        run_request("rem overflow", op_rem, MOST_NEG, {XLEN{1'b1}});
        run_request("divu most neg by all ones", op_divu, MOST_NEG, {XLEN{1'b1}});
        run_request("remu most neg by all ones", op_remu, MOST_NEG, {XLEN{1'b1}});
    endtask

    task automatic abort_multiply(input string name, input logic use_flush);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        a = 64'h0123_4567_89ab_cdef;
        b = 64'h0000_0000_dead_beef;
        @(negedge clk);
        req_valid = 1'b1;
        req.op    = op_mul;
        req.src1  = a;
        req.src2  = b;
        repeat (XLEN / 2) begin
            #1;
            check_value({name, " early done"}, '0, XLEN'(done));
            @(negedge clk);
        end
        // Abort halfway through the steps
        if (use_flush) begin
            flush = 1'b1;
        end else begin
            req_valid = 1'b0;
        end
        #1;
        check_value({name, " done at abort"}, '0, XLEN'(done));
        // Same request right after the abort cycle needs the full time from an idle counter
        run_request({name, " follow-up"}, op_mul, a, b);
    endtask

    // ----------------------------------------------------------
    // Sequence and watchdog
    // ----------------------------------------------------------
    initial begin
        reset     = 1'b1;
        flush     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        low_word_products();
        high_word_products();
        zero_operand_products();
        divide_and_remainder();
        special_divides();
        abort_multiply("abort by flush", 1'b1);
        abort_multiply("abort by valid drop", 1'b0);
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired after %0d ns, done never came", TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

endmodule

// File: project.f
muldiv_pkg.sv
mul_iter.sv
div_iter.sv
muldiv_unit.sv
muldiv_checker.sv
tb_muldiv.sv

// File: Makefile
SHELL     := /bin/bash
VERILATOR ?= verilator
TOP       ?= tb_muldiv
RTL_TOP   ?= muldiv_unit
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= muldiv_pkg.sv mul_iter.sv div_iter.sv muldiv_unit.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
